/* hdl/apb_gpio.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_gpio (
    input  logic                               HCLK,
    input  logic                               HRESETn,
    input  logic [apb_pkg::apb_addr_width-1:0] paddr,
    input  logic [apb_pkg::apb_data_width-1:0] pwdata,
    input  logic                               pwrite,
    input  logic                               psel,
    input  logic                               penable,
    output logic [apb_pkg::apb_data_width-1:0] prdata,
    output logic                               pready,
    output logic                               pslverr,
    input  logic [gpio_pkg::pad_num-1:0]       gpio_in,
    output logic [gpio_pkg::pad_num-1:0]       gpio_in_sync,
    output logic [gpio_pkg::pad_num-1:0]       gpio_out,
    output logic [gpio_pkg::pad_num-1:0]       gpio_dir,
    output logic                               interrupt
);

    import apb_pkg::*;
    import gpio_pkg::*;

    apb_req_t           req;
    gpio_wr_t           wr;
    gpio_cfg_t          cfg;
    logic               status_rd;
    logic [pad_num-1:0] pad_in;
    logic [pad_num-1:0] rise;
    logic [pad_num-1:0] fall;
    logic [pad_num-1:0] status;

    always_comb
    begin
        req.paddr   = paddr;
        req.pwdata  = pwdata;
        req.pwrite  = pwrite;
        req.psel    = psel;
        req.penable = penable;
    end

    gpio_apb_slave i_gpio_apb_slave (
        .req       (req),
        .cfg       (cfg),
        .pad_in    (pad_in),
        .status    (status),
        .wr        (wr),
        .status_rd (status_rd),
        .prdata    (prdata)
    );

    gpio_regs i_gpio_regs (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .wr      (wr),
        .cfg     (cfg)
    );

    gpio_input_sync i_gpio_input_sync (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .gpio_in (gpio_in),
        .en      (cfg.en),
        .sync    (gpio_in_sync),
        .pad_in  (pad_in),
        .rise    (rise),
        .fall    (fall)
    );

    gpio_irq i_gpio_irq (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .cfg       (cfg),
        .rise      (rise),
        .fall      (fall),
        .status_rd (status_rd),
        .status    (status),
        .interrupt (interrupt)
    );

    assign gpio_out = cfg.out;
    assign gpio_dir = cfg.dir;

    assign pready  = 1'b1;                          // No wait states
    assign pslverr = 1'b0;

endmodule

`default_nettype wire

/* hdl/apb_pkg.sv */
`default_nettype none

package apb_pkg;

    localparam int apb_addr_width = 12; // 4 KB slave window
    localparam int apb_data_width = 32;

    // Slave-side view of one APB transfer
    typedef struct packed {
        logic [apb_addr_width-1:0] paddr;
        logic [apb_data_width-1:0] pwdata;
        logic                      pwrite;
        logic                      psel;
        logic                      penable;
    } apb_req_t;

endpackage

`default_nettype wire

/* hdl/gpio_apb_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_apb_slave (
    input  apb_pkg::apb_req_t                  req,
    input  gpio_pkg::gpio_cfg_t                cfg,
    input  logic [gpio_pkg::pad_num-1:0]       pad_in,
    input  logic [gpio_pkg::pad_num-1:0]       status,
    output gpio_pkg::gpio_wr_t                 wr,
    output logic                               status_rd,
    output logic [apb_pkg::apb_data_width-1:0] prdata
);

    import gpio_pkg::*;

    gpio_reg_idx_t idx;
    logic          access;
    logic          rd_access;

    assign idx       = req.paddr[6:2];              // Upper bits alias the map
    assign access    = req.psel && req.penable;
    assign rd_access = access && !req.pwrite;

    always_comb
    begin
        wr.valid = access && req.pwrite;
        wr.idx   = idx;
        wr.data  = req.pwdata;
    end

    assign status_rd = rd_access && (idx == reg_intstatus);

    always_comb
    begin
        prdata = '0;
        if (rd_access)
        begin
            case (idx)
                reg_paddir:
                    prdata = cfg.dir;
                reg_gpioen:
                    prdata = cfg.en;
                reg_padin:
                    prdata = pad_in;
                reg_padout:
                    prdata = cfg.out;
                reg_inten:
                    prdata = cfg.inten;
                reg_inttype_lo:
                    prdata = cfg.inttype[pad_num/2-1:0];       // Two bits per pad
                reg_inttype_hi:
                    prdata = cfg.inttype[pad_num-1:pad_num/2];
                reg_intstatus:
                    prdata = status;
                default:
                    prdata = '0;                    // Set, clear and holes read zero
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/gpio_input_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_input_sync (
    input  logic                         HCLK,
    input  logic                         HRESETn,
    input  logic [gpio_pkg::pad_num-1:0] gpio_in,
    input  logic [gpio_pkg::pad_num-1:0] en,
    output logic [gpio_pkg::pad_num-1:0] sync,
    output logic [gpio_pkg::pad_num-1:0] pad_in,
    output logic [gpio_pkg::pad_num-1:0] rise,
    output logic [gpio_pkg::pad_num-1:0] fall
);

    import gpio_pkg::*;

    logic [num_groups-1:0] grp_en;
    logic [pad_num-1:0]    sync0;
    logic [pad_num-1:0]    sync1;
    logic [pad_num-1:0]    sample;

    always_comb
    begin
        for (int g = 0; g < num_groups; g++)
            grp_en[g] = |en[g*group_size +: group_size];
    end

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            sync0  <= '0;
            sync1  <= '0;
            sample <= '0;
        end
        else
        begin
            for (int i = 0; i < pad_num; i++)
            begin
                if (grp_en[i/group_size])           // Idle groups hold all stages
                begin
                    sync0[i]  <= gpio_in[i];
                    sync1[i]  <= sync0[i];
                    sample[i] <= sync1[i];
                end
            end
        end
    end

    assign sync   = sync1;
    assign pad_in = sample;
    assign rise   = sync1 & ~sample;
    assign fall   = ~sync1 & sample;

endmodule

`default_nettype wire

/* hdl/gpio_irq.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_irq (
    input  logic                         HCLK,
    input  logic                         HRESETn,
    input  gpio_pkg::gpio_cfg_t          cfg,
    input  logic [gpio_pkg::pad_num-1:0] rise,
    input  logic [gpio_pkg::pad_num-1:0] fall,
    input  logic                         status_rd,
    output logic [gpio_pkg::pad_num-1:0] status,
    output logic                         interrupt
);

    import gpio_pkg::*;

    logic [pad_num-1:0] match;
    logic [pad_num-1:0] hit;

    always_comb
    begin
        for (int i = 0; i < pad_num; i++)
        begin
            case (int_type_e'(cfg.inttype[i]))
                int_fall:
                    match[i] = fall[i];
                int_rise:
                    match[i] = rise[i];
                int_both:
                    match[i] = rise[i] | fall[i];
                int_none:
                    match[i] = 1'b0;
            endcase
        end
    end

    assign hit       = match & cfg.inten & cfg.en;
    assign interrupt = |hit;

    // New events win over the clear of a status read in the same cycle
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            status <= '0;
        end
        else if (interrupt)
        begin
            status <= status | hit;
        end
        else if (status_rd)
        begin
            status <= '0;
        end
    end

endmodule

`default_nettype wire

/* hdl/gpio_pkg.sv */
`default_nettype none

package gpio_pkg;

    localparam int pad_num    = 32;
    localparam int group_size = 4;                  // Pads per sampling enable
    localparam int num_groups = pad_num / group_size;

    typedef logic [4:0] gpio_reg_idx_t;             // Word index, address bits 6:2

    localparam gpio_reg_idx_t reg_paddir     = 5'd0; // 0x00
    localparam gpio_reg_idx_t reg_gpioen     = 5'd1; // 0x04
    localparam gpio_reg_idx_t reg_padin      = 5'd2; // 0x08
    localparam gpio_reg_idx_t reg_padout     = 5'd3; // 0x0C
    localparam gpio_reg_idx_t reg_padoutset  = 5'd4; // 0x10
    localparam gpio_reg_idx_t reg_padoutclr  = 5'd5; // 0x14
    localparam gpio_reg_idx_t reg_inten      = 5'd6; // 0x18
    localparam gpio_reg_idx_t reg_inttype_lo = 5'd7; // 0x1C, pads 0 to 15
    localparam gpio_reg_idx_t reg_inttype_hi = 5'd8; // 0x20, pads 16 to 31
    localparam gpio_reg_idx_t reg_intstatus  = 5'd9; // 0x24, clear on read

    typedef enum logic [1:0] {
        int_fall = 2'd0,
        int_rise = 2'd1,
        int_both = 2'd2,
        int_none = 2'd3
    } int_type_e;

    typedef struct packed {
        logic [pad_num-1:0]       dir;              // 1 drives the pad
        logic [pad_num-1:0]       out;
        logic [pad_num-1:0]       en;
        logic [pad_num-1:0]       inten;
        logic [pad_num-1:0][1:0]  inttype;          // Holds int_type_e codes
    } gpio_cfg_t;

    typedef struct packed {
        logic          valid;
        gpio_reg_idx_t idx;
        logic [31:0]   data;
    } gpio_wr_t;

endpackage

`default_nettype wire

/* hdl/gpio_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_regs (
    input  logic                HCLK,
    input  logic                HRESETn,
    input  gpio_pkg::gpio_wr_t  wr,
    output gpio_pkg::gpio_cfg_t cfg
);

    import gpio_pkg::*;

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            cfg <= '0;                              // Inputs, falling type
        end
        else if (wr.valid)
        begin
            case (wr.idx)
                reg_paddir:
                begin
                    cfg.dir <= wr.data;
                end
                reg_gpioen:
                begin
                    cfg.en <= wr.data;
                end
                reg_padout:
                begin
                    cfg.out <= wr.data;
                end
                reg_padoutset:
                begin
                    cfg.out <= cfg.out | wr.data;
                end
                reg_padoutclr:
                begin
                    cfg.out <= cfg.out & ~wr.data;
                end
                reg_inten:
                begin
                    cfg.inten <= wr.data;
                end
                reg_inttype_lo:
                begin
                    cfg.inttype[pad_num/2-1:0] <= wr.data;     // Pad i in bits 2i+1:2i
                end
                reg_inttype_hi:
                begin
                    cfg.inttype[pad_num-1:pad_num/2] <= wr.data;
                end
                default:
                begin
                    cfg <= cfg;                     // Read-only or unmapped
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* tb.f */
hdl/apb_pkg.sv
hdl/gpio_pkg.sv
hdl/gpio_apb_slave.sv
hdl/gpio_regs.sv
hdl/gpio_input_sync.sv
hdl/gpio_irq.sv
hdl/apb_gpio.sv
tests/tb_apb_gpio.sv

/* tests/tb_apb_gpio.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_apb_gpio;

    import apb_pkg::*;
    import gpio_pkg::*;

    localparam int clk_period  = 40;
    localparam int idle_cycles = 4;                 // PADIN trails gpio_in by three edges
    localparam int irq_window  = 5;

    typedef enum logic [2:0] {
        op_wr,
        op_rd,
        op_pin,
        op_edge,
        op_ports
    } op_e;

    typedef struct packed {
        op_e           op;
        gpio_reg_idx_t idx;
        logic [31:0]   data;
        logic [31:0]   exp;
    } entry_t;

    logic                      HCLK = 1'b0;
    logic                      HRESETn;
    logic [apb_addr_width-1:0] paddr;
    logic [apb_data_width-1:0] pwdata;
    logic                      pwrite;
    logic                      psel;
    logic                      penable;
    logic [apb_data_width-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
    logic [pad_num-1:0]        gpio_in;
    logic [pad_num-1:0]        gpio_in_sync;
    logic [pad_num-1:0]        gpio_out;
    logic [pad_num-1:0]        gpio_dir;
    logic                      interrupt;

    entry_t tbl[$];
    bit     table_ready = 1'b0;

    apb_gpio i_apb_gpio (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .pwrite       (pwrite),
        .psel         (psel),
        .penable      (penable),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .gpio_in      (gpio_in),
        .gpio_in_sync (gpio_in_sync),
        .gpio_out     (gpio_out),
        .gpio_dir     (gpio_dir),
        .interrupt    (interrupt)
    );

    always #(clk_period/2) HCLK = ~HCLK;

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, actual, expected);
            $display("tests failed");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    task automatic apb_write(input gpio_reg_idx_t idx, input logic [31:0] data);
        @(posedge HCLK);
        paddr   <= apb_addr_width'({idx, 2'b00});
        pwdata  <= data;
        pwrite  <= 1'b1;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge HCLK);
        penable <= 1'b1;
        @(posedge HCLK);                            // Write lands on this edge
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input gpio_reg_idx_t idx, output logic [31:0] data);
        @(posedge HCLK);
        paddr   <= apb_addr_width'({idx, 2'b00});
        pwrite  <= 1'b0;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge HCLK);
        penable <= 1'b1;
        @(negedge HCLK);
        data = prdata;                              // Mid access phase
        @(posedge HCLK);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic add_entry(input op_e op, input gpio_reg_idx_t idx,
                             input logic [31:0] data, input logic [31:0] exp);
        tbl.push_back(entry_t'{op, idx, data, exp});
    endtask

    // One pad, one type; a rising then a falling level change, each followed by two status reads
    task automatic add_edge_test(input int unsigned pad, input int_type_e t,
                                 input bit inten_on, input bit en_on);
        logic [31:0] bit_mask;
        logic [31:0] types;
        logic [1:0]  code;
        logic        armed;
        logic        fire_rise;
        logic        fire_fall;
        bit_mask  = 32'd1 << pad;
        code      = t;
        types     = {16{code}};
        armed     = inten_on && en_on;
        fire_rise = armed && (t == int_rise || t == int_both);
        fire_fall = armed && (t == int_fall || t == int_both);
        add_entry(op_wr, reg_inttype_lo, types, 0);
        add_entry(op_wr, reg_inttype_hi, types, 0);
        add_entry(op_wr, reg_inten, inten_on ? bit_mask : 32'd0, 0);
        add_entry(op_wr, reg_gpioen, en_on ? 32'hFFFF_FFFF : ~bit_mask, 0);
        add_entry(op_edge, 0, bit_mask, fire_rise);
        add_entry(op_rd, reg_intstatus, 0, fire_rise ? bit_mask : 32'd0);
        add_entry(op_rd, reg_intstatus, 0, 0);      // Cleared by the first read
        add_entry(op_edge, 0, 0, fire_fall);
        add_entry(op_rd, reg_intstatus, 0, fire_fall ? bit_mask : 32'd0);
        add_entry(op_rd, reg_intstatus, 0, 0);
    endtask

    task automatic build_table();
        logic [31:0]   d;
        logic [31:0]   out_model;
        logic [31:0]   dir_model;
        logic [31:0]   pad_model;
        logic [31:0]   grp_mask;
        int unsigned   pad;
        gpio_reg_idx_t rw_regs[6] = '{reg_paddir, reg_gpioen, reg_padout,
                                      reg_inten, reg_inttype_lo, reg_inttype_hi};
        for (int r = 0; r <= reg_intstatus; r++)
            add_entry(op_rd, r, 0, 0);              // Reset state of the whole map
        foreach (rw_regs[k])
        begin
            d = $urandom;
            add_entry(op_wr, rw_regs[k], d, 0);
            add_entry(op_rd, rw_regs[k], 0, d);
            if (rw_regs[k] == reg_paddir)
                dir_model = d;
            if (rw_regs[k] == reg_padout)
                out_model = d;
        end
        add_entry(op_ports, 0, dir_model, out_model);
        repeat (4)
        begin
            d = $urandom;
            out_model = out_model | d;
            add_entry(op_wr, reg_padoutset, d, 0);
            add_entry(op_rd, reg_padout, 0, out_model);
            d = $urandom;
            out_model = out_model & ~d;
            add_entry(op_wr, reg_padoutclr, d, 0);
            add_entry(op_rd, reg_padout, 0, out_model);
        end
        add_entry(op_ports, 0, dir_model, out_model);

        // PADIN with every group on, then with group 2 frozen
        add_entry(op_wr, reg_inten, 0, 0);
        add_entry(op_wr, reg_gpioen, 32'hFFFF_FFFF, 0);
        pad_model = $urandom;
        add_entry(op_pin, 0, pad_model, pad_model);
        add_entry(op_rd, reg_padin, 0, pad_model);
        grp_mask = 32'h0000_0F00;
        add_entry(op_wr, reg_gpioen, ~grp_mask, 0);
        d = $urandom;
        pad_model = (d & ~grp_mask) | (pad_model & grp_mask);
        add_entry(op_pin, 0, d, pad_model);
        add_entry(op_rd, reg_padin, 0, pad_model);
        add_entry(op_wr, reg_gpioen, 32'hFFFF_FFFF, 0);
        add_entry(op_pin, 0, 0, 0);
        add_entry(op_rd, reg_padin, 0, 0);
        add_entry(op_rd, reg_intstatus, 0, 0);

        for (int k = 0; k < 2; k++)
        begin
            pad = $urandom % pad_num;
            for (int t = 0; t < 4; t++)
                add_edge_test(pad, int_type_e'(t), 1'b1, 1'b1);
        end
        pad = $urandom % pad_num;
        add_edge_test(pad, int_both, 1'b0, 1'b1);   // Masked by inten
        add_edge_test(pad, int_both, 1'b1, 1'b0);   // Masked by en, group still live
    endtask

    initial
    begin
        entry_t      e;
        logic [31:0] rdata;
        logic        seen;
        void'($urandom(96));
        build_table();
        table_ready = 1'b1;
        HRESETn <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        pwrite  <= 1'b0;
        psel    <= 1'b0;
        penable <= 1'b0;
        gpio_in <= '0;
        repeat (2) @(posedge HCLK);
        HRESETn <= 1'b1;
        @(negedge HCLK);
        check("gpio_dir", gpio_dir, 0);
        check("interrupt", interrupt, 0);
        check("pready", pready, 1);
        check("pslverr", pslverr, 0);
        foreach (tbl[n])
        begin
            e = tbl[n];
            case (e.op)
                op_wr:
                    apb_write(e.idx, e.data);
                op_rd:
                begin
                    apb_read(e.idx, rdata);
                    check($sformatf("prdata (reg %0d)", e.idx), rdata, e.exp);
                end
                op_pin:
                begin
                    @(posedge HCLK);
                    gpio_in <= e.data;
                    repeat (idle_cycles) @(posedge HCLK);
                    @(negedge HCLK);
                    check("gpio_in_sync", gpio_in_sync, e.exp);
                end
                op_edge:
                begin
                    @(posedge HCLK);
                    gpio_in <= e.data;
                    seen = 1'b0;
                    for (int c = 0; c < irq_window && !seen; c++)
                    begin
                        @(negedge HCLK);
                        seen = interrupt;
                    end
                    check("interrupt", seen, e.exp);
                end
                default:
                begin
                    @(negedge HCLK);
                    check("gpio_dir", gpio_dir, e.data);
                    check("gpio_out", gpio_out, e.exp);
                end
            endcase
        end
        $display("all tests passed");
        $finish;
    end

    initial
    begin
        wait (table_ready);
        #(clk_period * 20 * tbl.size());
        $display("Timeout: the table did not finish within the watchdog limit");
        $display("tests failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire
